// ==== verification/cpuVectors.txt ====
# P <instr word address hex> <instruction hex>
# W <rd hex> <value hex> <cycles since previous write-back, 0 unchecked>
# C <pc after halt hex>
P 00 0100
P 01 7134
P 02 8112
P 03 0200
P 04 720F
P 05 0312
P 06 1432
P 07 2543
P 08 3654
P 09 4763
P 0A 0012
P 0B 0807
P 0C 6802
P 0D 5902
P 0E 0A91
P 0F 9000
W 1 0000 0
W 1 0034 1
W 1 1234 1
W 2 0000 1
W 2 000F 1
W 3 1243 1
W 4 1234 1
W 5 0077 1
W 6 0770 1
W 7 00EE 1
W 8 00EE 2
W 9 00EE 2
W A 1322 2
C 0020

// ==== list.f ====
+incdir+common
common/cpuPkg.sv
fetch/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
design/hazardUnit.sv
design/memoryStage.sv
design/cpu.sv
verification/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/cpuSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// ==== verification/cpuTb.sv ====
`default_nettype none

module cpuTb;

  bit                clk;
  logic              rst;
  logic              run;
  logic              progWe;
  cpuPkg::imemAddr_t progAddr;
  cpuPkg::word_t     progData;
  cpuPkg::word_t     pc;
  logic              hlt;
  logic              wbEn;
  cpuPkg::regAddr_t  wbReg;
  cpuPkg::word_t     wbData;

  // Contents of the vectors file
  cpuPkg::imemAddr_t progAddrQ [$];
  cpuPkg::word_t     progWordQ [$];
  cpuPkg::regAddr_t  expReg [$];  // Expected write-backs in arrival order
  cpuPkg::word_t     expVal [$];
  int                expGap [$];  // Cycles since previous write-back or 0 to skip
  cpuPkg::word_t     expPc;        // Frozen pc after HLT

  int   errors;
  int   checks;
  int   cycle;        // Counted on falling edges
  int   lastWbCycle;
  logic ok;

  cpu u_cpu (
    .clk(clk),
    .rst(rst),
    .run(run),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .pc(pc),
    .hlt(hlt),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Vectors file
  ////////////////////////////////////////////////////////////
  task automatic readVectors(output logic good);
    int                fd;
    int                n;
    logic [7:0]        tag;   // Single character line kind
    logic [8*120-1:0]  rest;
    cpuPkg::imemAddr_t a;
    cpuPkg::word_t     w;
    cpuPkg::regAddr_t  r;
    int                g;
    good = 1'b1;
    fd = $fopen("verification/cpuVectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/cpuVectors.txt");
      errors = errors + 1;
      good   = 1'b0;
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        case (tag)
          "#": n = $fgets(rest, fd);  // Column notes
          "P": begin
            n = $fscanf(fd, "%h %h", a, w);
            progAddrQ.push_back(a);
            progWordQ.push_back(w);
          end
          "W": begin
            n = $fscanf(fd, "%h %h %d", r, w, g);
            expReg.push_back(r);
            expVal.push_back(w);
            expGap.push_back(g);
          end
          "C": n = $fscanf(fd, "%h", expPc);
          default: begin
            $display("Vectors file has a line of unknown kind");
            errors = errors + 1;
            good   = 1'b0;
          end
        endcase
      end
      $fclose(fd);
      if ((progWordQ.size() == 0) || (expReg.size() == 0)) begin
        $display("Vectors file holds no program or no expected write-backs");
        errors = errors + 1;
        good   = 1'b0;
      end
    end
  endtask

  // Program goes in while run is low and then run rises
  task automatic loadProgram();
    int i;
    for (i = 0; i < progWordQ.size(); i++) begin
      @(posedge clk);
      progWe   <= 1'b1;
      progAddr <= progAddrQ[i];
      progData <= progWordQ[i];
    end
    @(posedge clk);
    progWe <= 1'b0;
    run    <= 1'b1;  // Last word lands on this edge
  endtask

  task automatic waitHalt(output logic good);
    int n;
    good = 1'b0;
    for (n = 0; (n < 200) && !good; n++) begin
      @(negedge clk);
      if (hlt) begin
        good = 1'b1;
      end
    end
    if (!good) begin
      $display("Timed out after 200 cycles waiting for hlt");
      errors = errors + 1;
    end
  endtask

  task automatic endRun();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Write-back monitor sampling on the falling edge
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (!run) begin  // Idle while reset and program load
      checkEq("wbEn", 16'(wbEn), 16'd0);
      checkEq("hlt", 16'(hlt), 16'd0);
      checkEq("pc", pc, 16'd0);
    end
    if (wbEn) begin
      if (expReg.size() == 0) begin
        $display("Write-back to R%0d arrived with none left to expect", wbReg);
        errors = errors + 1;
      end else begin
        checkEq("wbReg", 16'(wbReg), 16'(expReg.pop_front()));
        checkEq("wbData", wbData, expVal.pop_front());
        if (expGap[0] != 0) begin
          checkEq("wbGap", 16'(cycle - lastWbCycle), 16'(expGap[0]));  // Stall count
        end
        void'(expGap.pop_front());
      end
      lastWbCycle = cycle;
    end
  end

  initial begin
    rst         = 1'b1;
    run         = 1'b0;
    progWe      = 1'b0;
    progAddr    = '0;
    progData    = '0;
    errors      = 0;
    checks      = 0;
    cycle       = 0;
    lastWbCycle = 0;
    expPc       = 16'hffff;  // Odd value that no frozen pc can match
    readVectors(ok);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    if (ok) begin
      loadProgram();
      waitHalt(ok);
    end
    if (ok) begin
      if (expReg.size() != 0) begin
        $display("hlt rose with %0d expected write-backs still missing", expReg.size());
        errors = errors + 1;
      end
      // Halted core must stay frozen
      repeat (20) begin
        @(negedge clk);
        checkEq("hlt", 16'(hlt), 16'd1);
        checkEq("pc", pc, expPc);
      end
    end
    endRun();
  end

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
`default_nettype none

module cpu (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,       // Low while the program loads
  input  logic              progWe,
  input  cpuPkg::imemAddr_t progAddr,
  input  cpuPkg::word_t     progData,
  output cpuPkg::word_t     pc,
  output logic              hlt,
  output logic              wbEn,      // One pulse per register write
  output cpuPkg::regAddr_t  wbReg,
  output cpuPkg::word_t     wbData
);

  // IF/ID and stall control
  cpuPkg::word_t    ifInstr;
  logic             ifValid;
  logic             hold;
  logic             bubble;
  logic             haltSeen;
  cpuPkg::regAddr_t srcA;
  cpuPkg::regAddr_t srcB;

  // ID/EX
  cpuPkg::opcode_t  exOp;
  cpuPkg::word_t    exA;
  cpuPkg::word_t    exB;
  cpuPkg::word_t    exImm;
  cpuPkg::regAddr_t exSrcA;
  cpuPkg::regAddr_t exSrcB;
  cpuPkg::regAddr_t exRd;
  logic             exRegWrite;
  logic             exMemRead;
  logic             exMemWrite;
  logic             exHalt;

  // EX/MEM
  cpuPkg::word_t    memResult;
  cpuPkg::word_t    memStore;
  cpuPkg::regAddr_t memRd;
  logic             memRegWrite;
  logic             memRead;
  logic             memWrite;
  logic             memHalt;

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////
  fetchStage iFetch (
    .clk(clk),
    .rst(rst),
    .run(run),
    .hold(hold),
    .haltSeen(haltSeen),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .pc(pc),
    .ifInstr(ifInstr),
    .ifValid(ifValid)
  );

  decodeStage iDecode (
    .clk(clk),
    .rst(rst),
    .bubble(bubble),
    .ifInstr(ifInstr),
    .ifValid(ifValid),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData),
    .srcA(srcA),
    .srcB(srcB),
    .exOp(exOp),
    .exA(exA),
    .exB(exB),
    .exImm(exImm),
    .exSrcA(exSrcA),
    .exSrcB(exSrcB),
    .exRd(exRd),
    .exRegWrite(exRegWrite),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exHalt(exHalt),
    .haltSeen(haltSeen)
  );

  hazardUnit iHazard (
    .srcA(srcA),
    .srcB(srcB),
    .exRd(exRd),
    .exMemRead(exMemRead),
    .hold(hold),
    .bubble(bubble)
  );

  executeStage iExecute (
    .clk(clk),
    .rst(rst),
    .exOp(exOp),
    .exA(exA),
    .exB(exB),
    .exImm(exImm),
    .exSrcA(exSrcA),
    .exSrcB(exSrcB),
    .exRd(exRd),
    .exRegWrite(exRegWrite),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exHalt(exHalt),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData),
    .memResult(memResult),
    .memStore(memStore),
    .memRd(memRd),
    .memRegWrite(memRegWrite),
    .memRead(memRead),
    .memWrite(memWrite),
    .memHalt(memHalt)
  );

  memoryStage iMemory (
    .clk(clk),
    .rst(rst),
    .memResult(memResult),
    .memStore(memStore),
    .memRd(memRd),
    .memRegWrite(memRegWrite),
    .memRead(memRead),
    .memWrite(memWrite),
    .memHalt(memHalt),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData),
    .hlt(hlt)
  );

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
`default_nettype none

`include "cpuDefines.svh"

module memoryStage (
  input  logic             clk,
  input  logic             rst,
  input  cpuPkg::word_t    memResult,
  input  cpuPkg::word_t    memStore,
  input  cpuPkg::regAddr_t memRd,
  input  logic             memRegWrite,
  input  logic             memRead,
  input  logic             memWrite,
  input  logic             memHalt,
  output logic             wbEn,
  output cpuPkg::regAddr_t wbReg,
  output cpuPkg::word_t    wbData,
  output logic             hlt       // Sticky until reset
);

  cpuPkg::word_t     dmem [0:(1 << `DMEM_AW)-1];  // Data memory
  cpuPkg::dmemAddr_t dAddr;
  cpuPkg::word_t     loadWord;

  assign dAddr    = memResult[`DMEM_AW:1];  // Word index of byte address
  assign loadWord = dmem[dAddr];

  always_ff @(posedge clk) begin
    if (memWrite) begin
      dmem[dAddr] <= memStore;
    end
  end

  ////////////////////////////////////////////////////////////
  // MEM/WB register and write-back select
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wbEn <= 1'b0;
      hlt  <= 1'b0;
    end else begin
      wbEn <= memRegWrite;
      hlt  <= hlt || memHalt;  // HLT reaches write-back
    end
  end

  always_ff @(posedge clk) begin
    wbReg  <= memRd;
    wbData <= memRead ? loadWord : memResult;
  end

  // Fetch freezes at HLT, so nothing writes back after halt
  assert property (@(posedge clk) disable iff (rst) !(wbEn && hlt));

endmodule

`default_nettype wire

// ==== design/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
  input  cpuPkg::regAddr_t srcA,       // Decode sources, zero when unused
  input  cpuPkg::regAddr_t srcB,
  input  cpuPkg::regAddr_t exRd,
  input  logic             exMemRead,  // Load sitting in execute
  output logic             hold,
  output logic             bubble
);

  logic loadUse;

  // Loaded word only exists after memory, so the consumer waits one cycle
  always_comb begin
    loadUse = 1'b0;
    if (exMemRead && (exRd != '0)) begin
      loadUse = (exRd == srcA) || (exRd == srcB);
    end
  end

  assign hold   = loadUse;  // Freeze pc and IF/ID
  assign bubble = loadUse;  // Nop into ID/EX

endmodule

`default_nettype wire

// ==== execute/executeStage.sv ====
`default_nettype none

`include "cpuDefines.svh"

module executeStage (
  input  logic             clk,
  input  logic             rst,
  input  cpuPkg::opcode_t  exOp,
  input  cpuPkg::word_t    exA,
  input  cpuPkg::word_t    exB,
  input  cpuPkg::word_t    exImm,
  input  cpuPkg::regAddr_t exSrcA,
  input  cpuPkg::regAddr_t exSrcB,
  input  cpuPkg::regAddr_t exRd,
  input  logic             exRegWrite,
  input  logic             exMemRead,
  input  logic             exMemWrite,
  input  logic             exHalt,
  input  logic             wbEn,
  input  cpuPkg::regAddr_t wbReg,
  input  cpuPkg::word_t    wbData,
  output cpuPkg::word_t    memResult,  // ALU result or memory address
  output cpuPkg::word_t    memStore,
  output cpuPkg::regAddr_t memRd,
  output logic             memRegWrite,
  output logic             memRead,
  output logic             memWrite,
  output logic             memHalt
);

  cpuPkg::fwdSel_t selA;
  cpuPkg::fwdSel_t selB;
  cpuPkg::word_t   opA;
  cpuPkg::word_t   opB;
  cpuPkg::word_t   aluOut;

  ////////////////////////////////////////////////////////////
  // Forwarding select
  ////////////////////////////////////////////////////////////
  // Youngest producer wins, R0 is never forwarded
  function automatic cpuPkg::fwdSel_t pickSrc(input cpuPkg::regAddr_t src);
    if (src == '0) begin
      return 2'd0;
    end
    if (memRegWrite && (memRd == src)) begin
      return 2'd1;  // EX/MEM result
    end
    if (wbEn && (wbReg == src)) begin
      return 2'd2;  // Write-back value
    end
    return 2'd0;
  endfunction

  function automatic cpuPkg::word_t pickVal(input cpuPkg::fwdSel_t sel,
                                            input cpuPkg::word_t regVal);
    case (sel)
      2'd1:    return memResult;
      2'd2:    return wbData;
      default: return regVal;
    endcase
  endfunction

  always_comb begin
    selA = pickSrc(exSrcA);
    selB = pickSrc(exSrcB);
    opA  = pickVal(selA, exA);
    opB  = pickVal(selB, exB);  // Also the SW store data
  end

  // ALU
  always_comb begin
    case (exOp)
      `OP_ADD:         aluOut = opA + opB;
      `OP_SUB:         aluOut = opA - opB;
      `OP_XOR:         aluOut = opA ^ opB;
      `OP_SLL:         aluOut = opA << exImm[3:0];
      `OP_SRL:         aluOut = opA >> exImm[3:0];  // Logical shift
      `OP_LW, `OP_SW:  aluOut = opA + exImm;  // Byte address
      `OP_LLB:         aluOut = {opA[15:8], exImm[7:0]};
      `OP_LHB:         aluOut = {exImm[7:0], opA[7:0]};
      default:         aluOut = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      memRegWrite <= 1'b0;
      memRead     <= 1'b0;
      memWrite    <= 1'b0;
      memHalt     <= 1'b0;
    end else begin
      memRegWrite <= exRegWrite;
      memRead     <= exMemRead;
      memWrite    <= exMemWrite;
      memHalt     <= exHalt;
    end
  end

  always_ff @(posedge clk) begin
    memResult <= aluOut;
    memStore  <= opB;
    memRd     <= exRd;
  end

endmodule

`default_nettype wire

// ==== decode/decodeStage.sv ====
`default_nettype none

`include "cpuDefines.svh"

module decodeStage (
  input  logic             clk,
  input  logic             rst,
  input  logic             bubble,     // Load-use stall inserts a nop
  input  cpuPkg::word_t    ifInstr,
  input  logic             ifValid,
  input  logic             wbEn,
  input  cpuPkg::regAddr_t wbReg,
  input  cpuPkg::word_t    wbData,
  output cpuPkg::regAddr_t srcA,       // Zero when the operand is unused
  output cpuPkg::regAddr_t srcB,
  output cpuPkg::opcode_t  exOp,
  output cpuPkg::word_t    exA,
  output cpuPkg::word_t    exB,
  output cpuPkg::word_t    exImm,
  output cpuPkg::regAddr_t exSrcA,
  output cpuPkg::regAddr_t exSrcB,
  output cpuPkg::regAddr_t exRd,
  output logic             exRegWrite,
  output logic             exMemRead,
  output logic             exMemWrite,
  output logic             exHalt,
  output logic             haltSeen
);

  cpuPkg::opcode_t  op;
  cpuPkg::regAddr_t rd;
  cpuPkg::regAddr_t rs;
  cpuPkg::regAddr_t rt;
  cpuPkg::word_t    rsData;
  cpuPkg::word_t    rtData;
  cpuPkg::word_t    imm;
  logic             isByteLoad;
  logic             readsA;
  logic             readsB;
  logic             writesRd;
  logic             isHlt;
  logic             haltReg;

  assign op = ifInstr[15:12];
  assign rd = ifInstr[11:8];
  assign rs = ifInstr[7:4];
  assign rt = ifInstr[3:0];

  assign isByteLoad = (op == `OP_LLB) || (op == `OP_LHB);
  assign isHlt      = ifValid && (op == `OP_HLT);

  // Every opcode below HLT reads operand A
  assign readsA   = ifValid && (op <= `OP_LHB);
  assign readsB   = ifValid && ((op <= `OP_XOR) || (op == `OP_SW));
  assign writesRd = readsA && (op != `OP_SW) && (rd != '0);  // R0 writes dropped

  assign srcA = readsA ? (isByteLoad ? rd : rs) : '0;  // LLB/LHB keep the other byte of rd
  assign srcB = readsB ? ((op == `OP_SW) ? rd : rt) : '0;  // SW store data from rd

  regFile iRegFile (
    .clk(clk),
    .rst(rst),
    .rs(srcA),
    .rt(srcB),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData),
    .rsData(rsData),
    .rtData(rtData)
  );

  ////////////////////////////////////////////////////////////
  // Immediate build
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (op)
      `OP_LLB, `OP_LHB: imm = {8'h00, ifInstr[7:0]};
      `OP_LW, `OP_SW:   imm = {{11{ifInstr[3]}}, ifInstr[3:0], 1'b0};  // Signed word offset
      default:          imm = {12'h000, ifInstr[3:0]};  // Shift amount
    endcase
  end

  // Sticky so pc stays frozen once HLT moves on
  always_ff @(posedge clk) begin
    if (rst) begin
      haltReg <= 1'b0;
    end else if (isHlt) begin
      haltReg <= 1'b1;
    end
  end

  assign haltSeen = haltReg || isHlt;

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || bubble) begin
      exRegWrite <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exHalt     <= 1'b0;
    end else begin
      exRegWrite <= writesRd;
      exMemRead  <= ifValid && (op == `OP_LW);
      exMemWrite <= ifValid && (op == `OP_SW);
      exHalt     <= isHlt;
    end
  end

  always_ff @(posedge clk) begin
    if (bubble) begin
      exOp   <= '0;
      exA    <= '0;
      exB    <= '0;
      exImm  <= '0;
      exSrcA <= '0;
      exSrcB <= '0;
      exRd   <= '0;
    end else begin
      exOp   <= op;
      exA    <= rsData;
      exB    <= rtData;
      exImm  <= imm;
      exSrcA <= srcA;
      exSrcB <= srcB;
      exRd   <= rd;
    end
  end

endmodule

`default_nettype wire

// ==== decode/regFile.sv ====
`default_nettype none

`include "cpuDefines.svh"

module regFile (
  input  logic             clk,
  input  logic             rst,
  input  cpuPkg::regAddr_t rs,
  input  cpuPkg::regAddr_t rt,
  input  logic             wbEn,    // Write strobe from write-back
  input  cpuPkg::regAddr_t wbReg,
  input  cpuPkg::word_t    wbData,
  output cpuPkg::word_t    rsData,
  output cpuPkg::word_t    rtData
);

  cpuPkg::word_t regs [0:`NUM_REGS-1];

  // R0 reads zero, a same-cycle write is passed straight through
  function automatic cpuPkg::word_t readPort(input cpuPkg::regAddr_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wbEn && (wbReg == idx)) begin
      return wbData;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rsData = readPort(rs);
    rtData = readPort(rt);
  end

  always_ff @(posedge clk) begin
    if (wbEn && (wbReg != '0)) begin
      regs[wbReg] <= wbData;
    end
  end

  // Decode drops regWrite for rd zero, so R0 never comes back from write-back
  assert property (@(posedge clk) disable iff (rst) wbEn |-> (wbReg != '0));

endmodule

`default_nettype wire

// ==== fetch/fetchStage.sv ====
`default_nettype none

`include "cpuDefines.svh"

module fetchStage (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,       // Level, low holds fetch
  input  logic              hold,      // Load-use stall
  input  logic              haltSeen,  // HLT decoded, freeze pc
  input  logic              progWe,
  input  cpuPkg::imemAddr_t progAddr,
  input  cpuPkg::word_t     progData,
  output cpuPkg::word_t     pc,
  output cpuPkg::word_t     ifInstr,
  output logic              ifValid
);

  cpuPkg::word_t imem [0:(1 << `IMEM_AW)-1];  // Instruction memory
  logic          advance;

  assign advance = run && !hold && !haltSeen;

  // Program load port
  always_ff @(posedge clk) begin
    if (progWe) begin
      imem[progAddr] <= progData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (advance) begin
      pc <= pc + cpuPkg::word_t'(2);  // Byte addressed, one word per step
    end
  end

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      ifValid <= 1'b0;
    end else if (!hold) begin
      ifValid <= advance;  // Bubble when fetch cannot move
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ifInstr <= imem[pc[`IMEM_AW:1]];  // Word index from pc
    end
  end

  // Fetch only ever steps in whole words
  assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0);

endmodule

`default_nettype wire

// ==== common/cpuPkg.sv ====
`default_nettype none

`include "cpuDefines.svh"

////////////////////////////////////////////////////////////
// Shared datapath types
////////////////////////////////////////////////////////////
package cpuPkg;

  // One data word or instruction
  typedef logic [`WORD_W-1:0] word_t;

  // Register index into the register file
  typedef logic [`REG_ADDR_W-1:0] regAddr_t;

  typedef logic [3:0] opcode_t;  // Bits 15:12 of an instruction

  // Operand source select in execute
  // 0 register value, 1 EX/MEM result, 2 write-back value
  typedef logic [1:0] fwdSel_t;

  // Word addresses of the two memories
  typedef logic [`IMEM_AW-1:0] imemAddr_t;
  typedef logic [`DMEM_AW-1:0] dmemAddr_t;

endpackage

`default_nettype wire

// ==== common/cpuDefines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath widths
`define WORD_W      16  // Data and instruction word
`define REG_ADDR_W  4   // Register index
`define NUM_REGS    16

// Memory word address widths
`define IMEM_AW     8
`define DMEM_AW     8

// Opcode values in bits 15:12
`define OP_ADD      4'd0
`define OP_SUB      4'd1
`define OP_XOR      4'd2
`define OP_SLL      4'd3  // Shift rs left by imm
`define OP_SRL      4'd4  // Shift rs right by imm
`define OP_LW       4'd5
`define OP_SW       4'd6
`define OP_LLB      4'd7  // Replace low byte of rd
`define OP_LHB      4'd8  // Replace high byte of rd
`define OP_HLT      4'd9

`endif
